//--- logic/fe_consts.svh
/*
  fetch front end constants
  widths of addresses, instructions and fetch blocks, plus pc stepping
*/
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// sv39 virtual address
`define FE_VADDR_WIDTH 39

// one rv32/rv64 instruction
`define FE_INSTR_WIDTH 32

// dual-issue fetch block, slot 1 in the low half
`define FE_FETCH_WIDTH 64

// sequential step covers both slots
`define FE_PC_STEP 8
`define FE_SLOT_OFFSET 4

// back-end command opcode field
`define FE_CMD_OP_WIDTH 2

`endif

//--- logic/fe_pkg.sv
/*
  fetch front end types
  back-end command, fsm state and front-end queue message formats
*/
`default_nettype none
`include "fe_consts.svh"

package fe_pkg;

  // commands the back end may send
  typedef enum logic [`FE_CMD_OP_WIDTH-1:0] {
    e_op_pc_redirect = 2'd0,
    e_op_state_reset = 2'd1,
    e_op_wait        = 2'd2
  } fe_cmd_op_e;

  typedef struct packed {
    fe_cmd_op_e                  opcode;
    logic [`FE_VADDR_WIDTH-1:0]  vaddr;
  } fe_cmd_s;

  // wait: idle, run: fetching, stall: waiting to replay the resume pc
  typedef enum logic [1:0] {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

  typedef enum logic {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  // listed in priority order
  typedef enum logic [1:0] {
    e_instr_misaligned   = 2'd0,
    e_instr_access_fault = 2'd1,
    e_icache_miss        = 2'd2
  } fe_exc_code_e;

  typedef struct packed {
    fe_msg_type_e                msg_type;
    logic [`FE_VADDR_WIDTH-1:0]  pc;
    logic [`FE_INSTR_WIDTH-1:0]  instr;
    fe_exc_code_e                exc_code;
  } fe_queue_msg_s;

endpackage

`default_nettype wire

//--- logic/fe_instr_scan.sv
/*
  instruction scan
  flags control-flow instructions so the second slot can be dropped
*/
`default_nettype none
`include "fe_consts.svh"

module fe_instr_scan
  (
    input  logic [`FE_INSTR_WIDTH-1:0] instr_i,
    output logic                       ctrl_flow_o
  );

  // rv major opcodes for control transfers
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;

  logic is_branch;
  logic is_jal;
  logic is_jalr;

  assign is_branch = (instr_i[6:0] == op_branch);
  assign is_jal    = (instr_i[6:0] == op_jal);
  // jalr is only defined with funct3 zero
  assign is_jalr   = (instr_i[6:0] == op_jalr) & (instr_i[14:12] == 3'b000);

  assign ctrl_flow_o = is_branch | is_jal | is_jalr;

endmodule

`default_nettype wire

//--- logic/fe_pc_gen.sv
/*
  pc generator
  holds the IF1 pc, steps by a whole fetch block or takes a redirect
*/
`default_nettype none
`include "fe_consts.svh"

module fe_pc_gen
  (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       redirect_v_i,
    input  logic [`FE_VADDR_WIDTH-1:0] redirect_pc_i,
    input  logic                       advance_i,
    output logic [`FE_VADDR_WIDTH-1:0] pc_o
  );

  localparam logic [`FE_VADDR_WIDTH-1:0] pc_step = `FE_PC_STEP;

  logic [`FE_VADDR_WIDTH-1:0] pc_r;
  logic [`FE_VADDR_WIDTH-1:0] pc_seq;

  // no prediction, next block is always pc + 8
  assign pc_seq = pc_r + pc_step;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pc_r <= '0;
    end
    // a redirect beats a same-cycle advance
    else if (redirect_v_i)
    begin
      pc_r <= redirect_pc_i;
    end
    else if (advance_i)
    begin
      pc_r <= pc_seq;
    end
  end

  assign pc_o = pc_r;

endmodule

`default_nettype wire

//--- logic/fe_fetch_ctrl.sv
/*
  fetch control
  command decode, wait/run/stall fsm, stage valids and the resume pc
*/
`default_nettype none
`include "fe_consts.svh"

module fe_fetch_ctrl
  (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  fe_pkg::fe_cmd_s            fe_cmd_i,
    input  logic                       fe_cmd_v_i,
    output logic                       fe_cmd_yumi_o,
    input  logic                       fe_queue_ready_i,
    input  logic [`FE_VADDR_WIDTH-1:0] if2_pc_i,
    input  logic                       if2_exception_i,
    output logic                       redirect_v_o,
    output logic [`FE_VADDR_WIDTH-1:0] redirect_pc_o,
    output logic                       advance_o,
    output logic                       imem_req_v_o,
    output logic                       if2_v_o,
    output logic                       deliver_o
  );

  fe_pkg::fe_state_e state_r;
  fe_pkg::fe_state_e state_n;
  logic v_if1_r;
  logic v_if2_r;
  logic [`FE_VADDR_WIDTH-1:0] resume_r;
  logic redirect_cmd;
  logic state_reset_cmd;
  logic wait_cmd;
  logic fetch_fail;
  logic exc_deliver;
  logic stall;
  logic unstall;
  logic squash;

  // command decode, every command is taken the cycle it shows up
  assign redirect_cmd    = fe_cmd_v_i & (fe_cmd_i.opcode == fe_pkg::e_op_pc_redirect);
  assign state_reset_cmd = fe_cmd_v_i & (fe_cmd_i.opcode == fe_pkg::e_op_state_reset);
  assign wait_cmd        = fe_cmd_v_i & (fe_cmd_i.opcode == fe_pkg::e_op_wait);
  assign fe_cmd_yumi_o   = fe_cmd_v_i;

  // a command in flight kills the IF2 output
  assign deliver_o   = v_if2_r & fe_queue_ready_i & ~fe_cmd_v_i;
  assign fetch_fail  = v_if2_r & ~deliver_o;
  assign exc_deliver = deliver_o & if2_exception_i;
  assign stall       = fetch_fail | state_reset_cmd;
  // replay once the queue can take messages again
  assign unstall = (state_r == fe_pkg::e_stall) & fe_queue_ready_i & ~fe_cmd_v_i;
  // anything that changes flow throws away the fetch sitting in IF1
  assign squash = fe_cmd_v_i | fetch_fail | exc_deliver;

  always_comb
  begin
    state_n = state_r;
    if (redirect_cmd)
      state_n = fe_pkg::e_run;
    else if (wait_cmd)
      state_n = fe_pkg::e_wait;
    else if (stall)
      state_n = fe_pkg::e_stall;
    else if ((state_r == fe_pkg::e_run) & exc_deliver)
      // hold off until the back end steers us somewhere
      state_n = fe_pkg::e_wait;
    else if (unstall)
      state_n = fe_pkg::e_run;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= fe_pkg::e_wait;
      v_if1_r <= 1'b0;
      v_if2_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      v_if1_r <= (state_n == fe_pkg::e_run);
      v_if2_r <= v_if1_r & ~squash;
    end
  end

  // resume pc, command target first, else track IF2 while running
  always_ff @(posedge clk_i)
  begin
    if (redirect_cmd | state_reset_cmd)
      resume_r <= fe_cmd_i.vaddr;
    else if ((state_r == fe_pkg::e_run) & v_if2_r)
      resume_r <= if2_pc_i;
  end

  assign redirect_v_o  = redirect_cmd | unstall;
  assign redirect_pc_o = redirect_cmd ? fe_cmd_i.vaddr : resume_r;

  // every IF1 cycle issues a request and moves the pc on
  assign imem_req_v_o = v_if1_r;
  assign advance_o    = v_if1_r;
  assign if2_v_o      = v_if2_r;

endmodule

`default_nettype wire

//--- logic/fe_queue_pack.sv
/*
  IF2 stage and queue message packing
  captures the IF1 pc, ranks exceptions and forms both slot messages
*/
`default_nettype none
`include "fe_consts.svh"

module fe_queue_pack
  (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic [`FE_VADDR_WIDTH-1:0] if1_pc_i,
    input  logic                       imem_req_v_i,
    input  logic                       if2_v_i,
    input  logic                       deliver_i,
    input  logic [`FE_FETCH_WIDTH-1:0] imem_data_i,
    input  logic                       imem_data_v_i,
    input  logic                       imem_fault_i,
    output logic [`FE_VADDR_WIDTH-1:0] if2_pc_o,
    output logic                       if2_exception_o,
    output fe_pkg::fe_queue_msg_s      fe_queue1_o,
    output fe_pkg::fe_queue_msg_s      fe_queue2_o,
    output logic                       fe_queue1_v_o,
    output logic                       fe_queue2_v_o
  );

  localparam logic [`FE_VADDR_WIDTH-1:0] slot_offset = `FE_SLOT_OFFSET;

  logic [`FE_VADDR_WIDTH-1:0] if2_pc_r;
  logic misaligned_r;
  logic [`FE_INSTR_WIDTH-1:0] instr_lo;
  logic [`FE_INSTR_WIDTH-1:0] instr_hi;
  logic slot1_ctrl_flow;
  logic exc_any;
  fe_pkg::fe_exc_code_e exc_code;

  // pc follows the request into IF2, misalignment is known up front
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      if2_pc_r     <= '0;
      misaligned_r <= 1'b0;
    end
    else if (imem_req_v_i)
    begin
      if2_pc_r     <= if1_pc_i;
      misaligned_r <= |if1_pc_i[1:0];
    end
  end

  assign instr_lo = imem_data_i[`FE_INSTR_WIDTH-1:0];
  assign instr_hi = imem_data_i[`FE_FETCH_WIDTH-1:`FE_INSTR_WIDTH];

  fe_instr_scan i_scan
    (
      .instr_i     (instr_lo),
      .ctrl_flow_o (slot1_ctrl_flow)
    );

  // missing data counts as an icache miss
  assign exc_any         = misaligned_r | imem_fault_i | ~imem_data_v_i;
  assign if2_exception_o = if2_v_i & exc_any;

  always_comb
  begin
    if (misaligned_r)
      exc_code = fe_pkg::e_instr_misaligned;
    else if (imem_fault_i)
      exc_code = fe_pkg::e_instr_access_fault;
    else
      exc_code = fe_pkg::e_icache_miss;
  end

  always_comb
  begin
    fe_queue1_o       = '0;
    fe_queue1_o.pc    = if2_pc_r;
    fe_queue2_o       = '0;
    fe_queue2_o.msg_type = fe_pkg::e_fe_fetch;
    fe_queue2_o.pc    = if2_pc_r + slot_offset;
    fe_queue2_o.instr = instr_hi;
    if (exc_any)
    begin
      // exception rides on slot 1, no instruction
      fe_queue1_o.msg_type = fe_pkg::e_fe_exception;
      fe_queue1_o.exc_code = exc_code;
    end
    else
    begin
      fe_queue1_o.msg_type = fe_pkg::e_fe_fetch;
      fe_queue1_o.instr    = instr_lo;
    end
  end

  assign fe_queue1_v_o = deliver_i;
  // slot 2 sits in the shadow of a control transfer in slot 1
  assign fe_queue2_v_o = deliver_i & ~exc_any & ~slot1_ctrl_flow;
  assign if2_pc_o      = if2_pc_r;

endmodule

`default_nettype wire

//--- logic/fe_top.sv
/*
  dual-issue fetch front end
  pc generation, fetch control and queue packing around an external imem
*/
`default_nettype none
`include "fe_consts.svh"

module fe_top
  (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  fe_pkg::fe_cmd_s            fe_cmd_i,
    input  logic                       fe_cmd_v_i,
    output logic                       fe_cmd_yumi_o,
    output logic                       imem_req_v_o,
    output logic [`FE_VADDR_WIDTH-1:0] imem_req_pc_o,
    input  logic [`FE_FETCH_WIDTH-1:0] imem_data_i,
    input  logic                       imem_data_v_i,
    input  logic                       imem_fault_i,
    output fe_pkg::fe_queue_msg_s      fe_queue1_o,
    output fe_pkg::fe_queue_msg_s      fe_queue2_o,
    output logic                       fe_queue1_v_o,
    output logic                       fe_queue2_v_o,
    input  logic                       fe_queue_ready_i
  );

  logic [`FE_VADDR_WIDTH-1:0] if1_pc;
  logic [`FE_VADDR_WIDTH-1:0] if2_pc;
  logic [`FE_VADDR_WIDTH-1:0] redirect_pc;
  logic redirect_v;
  logic advance;
  logic req_v;
  logic if2_v;
  logic if2_exception;
  logic deliver;

  fe_pc_gen i_pc_gen
    (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .redirect_v_i  (redirect_v),
      .redirect_pc_i (redirect_pc),
      .advance_i     (advance),
      .pc_o          (if1_pc)
    );

  fe_fetch_ctrl i_fetch_ctrl
    (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .fe_cmd_i         (fe_cmd_i),
      .fe_cmd_v_i       (fe_cmd_v_i),
      .fe_cmd_yumi_o    (fe_cmd_yumi_o),
      .fe_queue_ready_i (fe_queue_ready_i),
      .if2_pc_i         (if2_pc),
      .if2_exception_i  (if2_exception),
      .redirect_v_o     (redirect_v),
      .redirect_pc_o    (redirect_pc),
      .advance_o        (advance),
      .imem_req_v_o     (req_v),
      .if2_v_o          (if2_v),
      .deliver_o        (deliver)
    );

  fe_queue_pack i_queue_pack
    (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .if1_pc_i        (if1_pc),
      .imem_req_v_i    (req_v),
      .if2_v_i         (if2_v),
      .deliver_i       (deliver),
      .imem_data_i     (imem_data_i),
      .imem_data_v_i   (imem_data_v_i),
      .imem_fault_i    (imem_fault_i),
      .if2_pc_o        (if2_pc),
      .if2_exception_o (if2_exception),
      .fe_queue1_o     (fe_queue1_o),
      .fe_queue2_o     (fe_queue2_o),
      .fe_queue1_v_o   (fe_queue1_v_o),
      .fe_queue2_v_o   (fe_queue2_v_o)
    );

  // IF1 pc goes straight out with the request
  assign imem_req_v_o  = req_v;
  assign imem_req_pc_o = if1_pc;

endmodule

`default_nettype wire

//--- tests/fe_tb.sv
/*
  testbench for the dual-issue fetch front end
  one-cycle imem model, back-end commands, queue back-pressure and message scoreboard
*/
`default_nettype none
`include "fe_consts.svh"

module fe_tb;

  localparam int clk_period = 4;
  localparam int wait_limit = 40;
  // per-test cycle budgets summed by the watchdog
  localparam int t1_cycles = 50;
  localparam int t2_cycles = 400;
  localparam int t3_cycles = 50;
  localparam int t4_cycles = 3 * (wait_limit + 12);
  localparam int t5_cycles = 2 * wait_limit + 24;
  localparam int watchdog_cycles =
    t1_cycles + t2_cycles + t3_cycles + t4_cycles + t5_cycles + 100;

  localparam logic [`FE_VADDR_WIDTH-1:0] first_pc  = 39'h00_0000_0100;
  localparam logic [`FE_VADDR_WIDTH-1:0] seq_pc    = 39'h00_1234_5600;
  localparam logic [`FE_VADDR_WIDTH-1:0] br_pc     = 39'h00_0000_2000;
  localparam logic [`FE_VADDR_WIDTH-1:0] jal_pc    = 39'h00_0000_2008;
  localparam logic [`FE_VADDR_WIDTH-1:0] jalr_pc   = 39'h00_0000_2010;
  // fault block also has no valid data so fault must win over miss
  localparam logic [`FE_VADDR_WIDTH-1:0] fault_pc  = 39'h00_0000_3000;
  localparam logic [`FE_VADDR_WIDTH-1:0] miss_pc   = 39'h00_0000_4000;
  localparam logic [`FE_VADDR_WIDTH-1:0] run_pc    = 39'h7f_0000_0040;
  localparam logic [`FE_VADDR_WIDTH-1:0] resume_pc = 39'h55_5555_5550;

  logic clk_i;
  logic reset_i;
  fe_pkg::fe_cmd_s fe_cmd_i;
  logic fe_cmd_v_i;
  logic fe_cmd_yumi_o;
  logic imem_req_v_o;
  logic [`FE_VADDR_WIDTH-1:0] imem_req_pc_o;
  logic [`FE_FETCH_WIDTH-1:0] imem_data_i;
  logic imem_data_v_i;
  logic imem_fault_i;
  fe_pkg::fe_queue_msg_s fe_queue1_o;
  fe_pkg::fe_queue_msg_s fe_queue2_o;
  logic fe_queue1_v_o;
  logic fe_queue2_v_o;
  logic fe_queue_ready_i;

  // scoreboard state
  logic [`FE_VADDR_WIDTH-1:0] exp_pc;
  logic quiet;
  logic halted;
  logic [2:0] exc_exp;
  logic slot2_exp;
  logic mem_v_q;
  logic [`FE_VADDR_WIDTH-1:0] mem_pc_q;
  int delivered = 0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_err_start = 0;
  string test_name = "reset";

  fe_top i_dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  function automatic logic in_block(input logic [`FE_VADDR_WIDTH-1:0] addr,
                                    input logic [`FE_VADDR_WIDTH-1:0] blk);
    return addr[`FE_VADDR_WIDTH-1:3] == blk[`FE_VADDR_WIDTH-1:3];
  endfunction

  function automatic logic is_ctrl_flow(input logic [`FE_VADDR_WIDTH-1:0] addr);
    return (addr == br_pc) || (addr == jal_pc) || (addr == jalr_pc);
  endfunction

  // memory contents fold in every address bit
  function automatic logic [31:0] instr_at(input logic [`FE_VADDR_WIDTH-1:0] addr);
    logic [31:0] fold;
    logic [24:0] body;
    fold = addr[31:0] ^ {23'd0, addr[38:32], 2'd0};
    body = fold[26:2] ^ {18'd0, fold[1:0], fold[31:27]};
    if (addr == br_pc)
      return {body[24:8], 3'b000, body[4:0], 7'b1100011};
    if (addr == jal_pc)
      return {body[24:8], 3'b000, body[4:0], 7'b1101111};
    if (addr == jalr_pc)
      return {body[24:8], 3'b000, body[4:0], 7'b1100111};
    // plain op-imm everywhere else
    return {body, 7'b0010011};
  endfunction

  // msb flags an exception and the low bits hold the expected code
  function automatic logic [2:0] exception_for(input logic [`FE_VADDR_WIDTH-1:0] addr);
    if (addr[1:0] != 2'b00)
      return {1'b1, fe_pkg::e_instr_misaligned};
    if (in_block(addr, fault_pc))
      return {1'b1, fe_pkg::e_instr_access_fault};
    if (in_block(addr, miss_pc))
      return {1'b1, fe_pkg::e_icache_miss};
    return 3'b000;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("mismatch %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("error in %s: %s", test_name, what);
    errors++;
  endtask

  // imem answers the request of the previous cycle
  initial
  begin
    imem_data_i   = '0;
    imem_data_v_i = 1'b0;
    imem_fault_i  = 1'b0;
    mem_v_q       = 1'b0;
    mem_pc_q      = '0;
    forever
    begin
      @(negedge clk_i);
      imem_data_i   = {instr_at(mem_pc_q + `FE_SLOT_OFFSET), instr_at(mem_pc_q)};
      imem_fault_i  = mem_v_q & in_block(mem_pc_q, fault_pc);
      imem_data_v_i = mem_v_q & !in_block(mem_pc_q, fault_pc) & !in_block(mem_pc_q, miss_pc);
      mem_v_q  = imem_req_v_o;
      mem_pc_q = imem_req_pc_o;
    end
  end

  // command is always taken in the cycle it is offered
  yumi_same_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_cmd_yumi_o == fe_cmd_v_i)
    else report_failure("command valid not taken in the same cycle");

  // slot 2 never goes out on its own
  slot2_with_slot1: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_queue2_v_o |-> fe_queue1_v_o)
    else report_failure("slot 2 valid without slot 1");

  // scoreboard follows commands and checks every delivered message
  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      quiet  = 1'b1;
      halted = 1'b0;
      exp_pc = '0;
    end
    else
    begin
      if (quiet || halted)
      begin
        assert (!imem_req_v_o && !fe_queue1_v_o && !fe_queue2_v_o)
          else report_failure("request or message while the front end should be idle");
      end
      if (fe_queue1_v_o && fe_queue_ready_i)
      begin
        delivered++;
        exc_exp = exception_for(exp_pc);
        assert (fe_queue1_o.pc == exp_pc)
          else report_mismatch("slot 1 pc", exp_pc, fe_queue1_o.pc);
        if (exc_exp[2])
        begin
          assert (fe_queue1_o.msg_type == fe_pkg::e_fe_exception)
            else report_mismatch("slot 1 type", fe_pkg::e_fe_exception, fe_queue1_o.msg_type);
          assert (fe_queue1_o.exc_code == exc_exp[1:0])
            else report_mismatch("exception code", exc_exp[1:0], fe_queue1_o.exc_code);
          assert (!fe_queue2_v_o)
            else report_failure("slot 2 valid next to an exception");
          // nothing more until the back end steers again
          halted = 1'b1;
        end
        else
        begin
          slot2_exp = !is_ctrl_flow(exp_pc);
          assert (fe_queue1_o.msg_type == fe_pkg::e_fe_fetch)
            else report_mismatch("slot 1 type", fe_pkg::e_fe_fetch, fe_queue1_o.msg_type);
          assert (fe_queue1_o.instr == instr_at(exp_pc))
            else report_mismatch("slot 1 instr", instr_at(exp_pc), fe_queue1_o.instr);
          assert (fe_queue2_v_o == slot2_exp)
            else report_mismatch("slot 2 valid", slot2_exp, fe_queue2_v_o);
          if (slot2_exp)
          begin
            assert (fe_queue2_o.msg_type == fe_pkg::e_fe_fetch)
              else report_mismatch("slot 2 type", fe_pkg::e_fe_fetch, fe_queue2_o.msg_type);
            assert (fe_queue2_o.pc == exp_pc + `FE_SLOT_OFFSET)
              else report_mismatch("slot 2 pc", exp_pc + `FE_SLOT_OFFSET, fe_queue2_o.pc);
            assert (fe_queue2_o.instr == instr_at(exp_pc + `FE_SLOT_OFFSET))
              else report_mismatch("slot 2 instr", instr_at(exp_pc + `FE_SLOT_OFFSET),
                                   fe_queue2_o.instr);
          end
          exp_pc = exp_pc + `FE_PC_STEP;
        end
      end
      if (fe_cmd_v_i)
      begin
        case (fe_cmd_i.opcode)
          fe_pkg::e_op_wait:
            quiet = 1'b1;
          default:
          begin
            // redirect and state reset both restart at the command vaddr
            exp_pc = fe_cmd_i.vaddr;
            quiet  = 1'b0;
            halted = 1'b0;
          end
        endcase
      end
    end
  end

  task automatic send_cmd(input fe_pkg::fe_cmd_op_e op,
                          input logic [`FE_VADDR_WIDTH-1:0] addr);
    @(negedge clk_i);
    fe_cmd_i.opcode = op;
    fe_cmd_i.vaddr  = addr;
    fe_cmd_v_i      = 1'b1;
    @(negedge clk_i);
    fe_cmd_v_i = 1'b0;
  endtask

  // random ready gives roughly one stall in four cycles
  task automatic wait_messages(input int count, input int limit, input logic random_ready);
    int start;
    int cycles;
    start  = delivered;
    cycles = 0;
    while ((delivered - start) < count && cycles < limit)
    begin
      @(negedge clk_i);
      fe_queue_ready_i = random_ready ? (($urandom % 4) != 0) : 1'b1;
      cycles++;
    end
    if ((delivered - start) < count)
      report_failure("timed out waiting for queue messages");
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) @(negedge clk_i);
  endtask

  task automatic raise_exception(input logic [`FE_VADDR_WIDTH-1:0] addr);
    send_cmd(fe_pkg::e_op_pc_redirect, addr);
    wait_messages(1, wait_limit, 1'b0);
    idle_cycles(8);
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == test_err_start)
      $display("test %s: passed", test_name);
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - test_err_start);
    end
  endtask

  initial
  begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(61185));
    reset_i          = 1'b1;
    fe_cmd_i         = '0;
    fe_cmd_v_i       = 1'b0;
    fe_queue_ready_i = 1'b1;
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;

    start_test("idle_then_redirect");
    idle_cycles(6);
    send_cmd(fe_pkg::e_op_pc_redirect, first_pc);
    wait_messages(2, wait_limit, 1'b0);
    finish_test();

    start_test("sequential_backpressure");
    send_cmd(fe_pkg::e_op_pc_redirect, seq_pc);
    wait_messages(40, t2_cycles - 20, 1'b1);
    finish_test();

    start_test("branch_suppression");
    send_cmd(fe_pkg::e_op_pc_redirect, br_pc);
    wait_messages(4, wait_limit, 1'b0);
    finish_test();

    start_test("exception_codes");
    raise_exception(fault_pc + 2);
    raise_exception(fault_pc);
    raise_exception(miss_pc);
    finish_test();

    start_test("wait_and_state_reset");
    send_cmd(fe_pkg::e_op_pc_redirect, run_pc);
    wait_messages(3, wait_limit, 1'b0);
    send_cmd(fe_pkg::e_op_wait, '0);
    idle_cycles(10);
    @(negedge clk_i);
    fe_queue_ready_i = 1'b0;
    // stays in stall until ready comes back
    send_cmd(fe_pkg::e_op_state_reset, resume_pc);
    repeat (4)
    begin
      @(negedge clk_i);
      assert (!imem_req_v_o)
        else report_failure("memory request while stalled and the queue is not ready");
    end
    wait_messages(3, wait_limit, 1'b0);
    finish_test();

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+logic
logic/fe_pkg.sv
logic/fe_instr_scan.sv
logic/fe_pc_gen.sv
logic/fe_fetch_ctrl.sv
logic/fe_queue_pack.sv
logic/fe_top.sv
tests/fe_tb.sv

//--- Bender.yml
package:
  name: fe_core

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/fe_pkg.sv
      - logic/fe_instr_scan.sv
      - logic/fe_pc_gen.sv
      - logic/fe_fetch_ctrl.sv
      - logic/fe_queue_pack.sv
      - logic/fe_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tests/fe_tb.sv
